//--- common/impulse_pkg.sv
package impulse_pkg;

    // ########################################
    // Audio data types
    // ########################################

    typedef logic signed [15:0] sample_t;  // One audio sample, two's complement.

    typedef logic [15:0] addr_t;  // Word address into the impulse memory.

    typedef logic [15:0] count_t;  // Sample periods, for both delay and record length.

    // ########################################
    // Capture sequencing
    // ########################################

    typedef enum logic [2:0] {
        WAITING_FOR_IMPULSE = 3'd0,
        DELAYING            = 3'd1,
        RECORDING           = 3'd2,
        COMPLETE            = 3'd3
    } capture_state_t;

    // ########################################
    // Impulse shape
    // ########################################

    // Positive full scale, played for exactly one sample period.
    localparam sample_t IMPULSE_AMP = 16'sh7FFF;

endpackage

//--- logic/impulse_generator.sv
module impulse_generator
    import impulse_pkg::*;
(
    input  logic    audio_clk,
    input  logic    rst_in,
    input  logic    audio_trigger,
    input  logic    record_impulse_trigger,
    output sample_t impulse_out,
    output logic    impulse_done
);

    typedef enum logic [1:0] {
        GEN_IDLE    = 2'd0,
        GEN_ARMED   = 2'd1,
        GEN_PLAYING = 2'd2
    } gen_state_t;

    gen_state_t gen_state;

    // ########################################
    // Impulse sequencer
    // ########################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            gen_state    <= GEN_IDLE;
            impulse_out  <= '0;
            impulse_done <= 1'b0;
        end else begin
            impulse_done <= 1'b0;
            case (gen_state)
                GEN_IDLE: begin
                    // The cycle of the done pulse still belongs to the last impulse.
                    if (record_impulse_trigger && !impulse_done) begin
                        gen_state <= GEN_ARMED;
                    end
                end
                GEN_ARMED: begin
                    if (audio_trigger) begin
                        impulse_out <= IMPULSE_AMP;  // Aligned to a sample boundary.
                        gen_state   <= GEN_PLAYING;
                    end
                end
                GEN_PLAYING: begin
                    if (audio_trigger) begin
                        impulse_out  <= '0;
                        impulse_done <= 1'b1;  // Delay counting starts from this strobe.
                        gen_state    <= GEN_IDLE;
                    end
                end
                default: begin
                    impulse_out <= '0;
                    gen_state   <= GEN_IDLE;
                end
            endcase
        end
    end

endmodule

//--- capture/sample_counter.sv
module sample_counter
    import impulse_pkg::*;
(
    input  logic   audio_clk,
    input  logic   rst_in,
    input  logic   clear,
    input  logic   audio_trigger,
    input  count_t limit,
    output count_t count,
    output logic   last_step
);

    // ########################################
    // Strobe counter
    // ########################################

    assign last_step = (count == limit - count_t'(1));

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (audio_trigger) begin
            if (last_step) begin
                count <= '0;  // Wrap so the next phase starts from zero.
            end else begin
                count <= count + count_t'(1);
            end
        end
    end

    // The owner only changes the limit when the count has wrapped or is held clear.
    a_count_below_limit : assert property (
        @(posedge audio_clk) disable iff (rst_in)
        (limit != '0) |-> (count != limit)
    );

endmodule

//--- capture/capture_fsm.sv
module capture_fsm
    import impulse_pkg::*;
#(
    parameter int impulse_length = 48000
) (
    input  logic    audio_clk,
    input  logic    rst_in,
    input  logic    audio_trigger,
    input  sample_t audio_in,
    input  count_t  delay_length,
    input  logic    redo_impulse,
    input  logic    impulse_done,
    input  logic    last_step,
    input  count_t  count,
    output logic    counter_clear,
    output count_t  counter_limit,
    output logic    write_en,
    output addr_t   write_addr,
    output sample_t write_data,
    output logic    impulse_recorded
);

    capture_state_t state;

    // ########################################
    // Phase sequencing
    // ########################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state            <= WAITING_FOR_IMPULSE;
            counter_limit    <= '0;
            impulse_recorded <= 1'b0;
        end else begin
            case (state)
                WAITING_FOR_IMPULSE: begin
                    if (impulse_done) begin
                        if (delay_length == '0) begin
                            counter_limit <= count_t'(impulse_length);  // Nothing to skip.
                            state         <= RECORDING;
                        end else begin
                            counter_limit <= delay_length;
                            state         <= DELAYING;
                        end
                    end
                end
                DELAYING: begin
                    if (audio_trigger && last_step) begin
                        counter_limit <= count_t'(impulse_length);  // Counter wraps to 0 here.
                        state         <= RECORDING;
                    end
                end
                RECORDING: begin
                    if (audio_trigger && last_step) begin
                        impulse_recorded <= 1'b1;  // Last sample is written on this edge.
                        state            <= COMPLETE;
                    end
                end
                COMPLETE: begin
                    if (redo_impulse) begin
                        impulse_recorded <= 1'b0;
                        state            <= WAITING_FOR_IMPULSE;
                    end
                end
                default: begin
                    impulse_recorded <= 1'b0;
                    state            <= WAITING_FOR_IMPULSE;
                end
            endcase
        end
    end

    // ########################################
    // Counter and memory control
    // ########################################

    // Holding the counter at zero also marks the capture as ready for a new impulse.
    assign counter_clear = (state == WAITING_FOR_IMPULSE);

    assign write_en   = (state == RECORDING) && audio_trigger;  // Write on the strobe edge.
    assign write_addr = addr_t'(count);
    assign write_data = audio_in;

    // Writes stay inside the loaded record length and stop once completion is flagged.
    a_write_in_record_phase : assert property (
        @(posedge audio_clk) disable iff (rst_in)
        write_en |-> !impulse_recorded && (count < counter_limit)
    );

endmodule

//--- logic/impulse_memory.sv
module impulse_memory
    import impulse_pkg::*;
#(
    parameter int impulse_length = 48000
) (
    input  logic    audio_clk,
    input  logic    write_en,
    input  addr_t   write_addr,
    input  sample_t write_data,
    input  addr_t   read_addr,
    output sample_t read_data
);

    localparam int addr_bits = $clog2(impulse_length);  // Index width for the array depth.

    // ########################################
    // Sample storage
    // ########################################

    sample_t mem [impulse_length];  // One entry per recorded sample period.

    always_ff @(posedge audio_clk) begin
        if (write_en) begin
            mem[write_addr[addr_bits-1:0]] <= write_data;
        end
    end

    // Read port for the convolution stage, one clock of latency.
    always_ff @(posedge audio_clk) begin
        read_data <= mem[read_addr[addr_bits-1:0]];
    end

    // The capture sequencer must stop addressing at the end of the response.
    a_write_in_range : assert property (
        @(posedge audio_clk)
        write_en |-> (int'(write_addr) < impulse_length)
    );

endmodule

//--- logic/record_impulse.sv
module record_impulse
    import impulse_pkg::*;
#(
    parameter int impulse_length = 48000
) (
    input  logic    audio_clk,
    input  logic    rst_in,
    input  logic    audio_trigger,
    input  sample_t audio_in,
    input  logic    record_impulse_trigger,
    input  count_t  delay_length,
    input  logic    redo_impulse,
    input  addr_t   read_addr,
    output sample_t read_data,
    output sample_t impulse_out,
    output logic    impulse_recorded
);

    logic    impulse_done;
    logic    arm_request;
    logic    counter_clear;
    count_t  counter_limit;
    count_t  count;
    logic    last_step;
    logic    write_en;
    addr_t   write_addr;
    sample_t write_data;

    // ########################################
    // Impulse playback
    // ########################################

    // Requests only count while the capture waits for an impulse.
    assign arm_request = record_impulse_trigger & counter_clear;

    impulse_generator i_impulse_generator (
        .audio_clk              (audio_clk),
        .rst_in                 (rst_in),
        .audio_trigger          (audio_trigger),
        .record_impulse_trigger (arm_request),
        .impulse_out            (impulse_out),
        .impulse_done           (impulse_done)
    );

    // ########################################
    // Capture
    // ########################################

    capture_fsm #(
        .impulse_length (impulse_length)
    ) i_capture_fsm (
        .audio_clk        (audio_clk),
        .rst_in           (rst_in),
        .audio_trigger    (audio_trigger),
        .audio_in         (audio_in),
        .delay_length     (delay_length),
        .redo_impulse     (redo_impulse),
        .impulse_done     (impulse_done),
        .last_step        (last_step),
        .count            (count),
        .counter_clear    (counter_clear),
        .counter_limit    (counter_limit),
        .write_en         (write_en),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .impulse_recorded (impulse_recorded)
    );

    sample_counter i_sample_counter (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .clear         (counter_clear),
        .audio_trigger (audio_trigger),
        .limit         (counter_limit),
        .count         (count),
        .last_step     (last_step)
    );

    impulse_memory #(
        .impulse_length (impulse_length)
    ) i_impulse_memory (
        .audio_clk  (audio_clk),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

endmodule

//--- verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ########################################
// Result checks
// ########################################

task automatic check_sample(input sample_t actual, input sample_t expected, input string what);
    if (actual !== expected) begin
        stop_on_failure($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                  $time, what, actual, expected));
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        stop_on_failure($sformatf("mismatch at time %0t: %s is %b, expected %b",
                                  $time, what, actual, expected));
    end
endtask

// ########################################
// Stimulus source
// ########################################

// Fibonacci LFSR with taps 16, 14, 13 and 11. Each call shifts one new bit into bit 0.
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

`endif

//--- verification/tb_record_impulse.sv
module tb_record_impulse
    import impulse_pkg::*;
();

    localparam int impulse_length = 16;
    localparam int clk_period     = 20;
    localparam int reset_cycles   = 3;
    localparam int strobe_period  = 8;  // Clocks per audio sample period.
    localparam int num_tests      = 6;
    localparam int longest_delay  = 9;
    localparam int watchdog_time  =
        num_tests * (longest_delay + impulse_length + 8) * strobe_period * clk_period
        + 100 * clk_period;

    logic    audio_clk = 1'b0;
    logic    rst_in;
    logic    audio_trigger;
    sample_t audio_in;
    logic    record_impulse_trigger;
    count_t  delay_length;
    logic    redo_impulse;
    addr_t   read_addr;
    sample_t read_data;
    sample_t impulse_out;
    logic    impulse_recorded;

    sample_t     strobe_log[$];  // audio_in of every strobe, indexed by strobe number.
    int          last_strobe = -1;
    int          stored_window;  // Strobe whose sample should sit at address 0.
    logic [15:0] lfsr_state = 16'd20;

    record_impulse #(
        .impulse_length (impulse_length)
    ) i_dut (
        .audio_clk              (audio_clk),
        .rst_in                 (rst_in),
        .audio_trigger          (audio_trigger),
        .audio_in               (audio_in),
        .record_impulse_trigger (record_impulse_trigger),
        .delay_length           (delay_length),
        .redo_impulse           (redo_impulse),
        .read_addr              (read_addr),
        .read_data              (read_data),
        .impulse_out            (impulse_out),
        .impulse_recorded       (impulse_recorded)
    );

    always #(clk_period / 2) audio_clk = ~audio_clk;

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    // ########################################
    // Audio strobes and watchdog
    // ########################################

    initial begin : strobe_source
        sample_t value;
        audio_trigger = 1'b0;
        audio_in      = '0;
        value         = '0;
        repeat (reset_cycles + 1) @(negedge audio_clk);
        forever begin
            for (int b = 0; b < 16; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                value      = {value[14:0], lfsr_state[0]};
            end
            audio_in      = value;
            audio_trigger = 1'b1;
            strobe_log.push_back(value);
            last_strobe = last_strobe + 1;
            $display("strobe %0d audio_in %h", last_strobe, value);
            @(negedge audio_clk);
            audio_trigger = 1'b0;
            repeat (strobe_period - 1) @(negedge audio_clk);
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        stop_on_failure($sformatf("timeout: the tests did not finish within %0d time units",
                                  watchdog_time));
    end

    // ########################################
    // Helpers
    // ########################################

    // Returns on the falling edge right after a strobe has been taken by the DUT.
    task automatic wait_next_strobe(output int index);
        @(posedge audio_clk);
        while (audio_trigger !== 1'b1) @(posedge audio_clk);
        index = last_strobe;
        @(negedge audio_clk);
    endtask

    task automatic start_capture(input count_t delay, output int end_strobe);
        int seen;
        wait_next_strobe(seen);
        delay_length           = delay;
        record_impulse_trigger = 1'b1;
        @(negedge audio_clk);
        record_impulse_trigger = 1'b0;
        end_strobe             = seen + 2;  // Impulse plays on seen+1 and ends on seen+2.
    endtask

    task automatic wait_for_recorded(input int max_strobes);
        int cycles;
        cycles = 0;
        while (impulse_recorded !== 1'b1 && cycles < max_strobes * strobe_period) begin
            @(negedge audio_clk);
            cycles++;
        end
        if (impulse_recorded !== 1'b1) begin
            stop_on_failure($sformatf("capture did not complete within %0d strobes",
                                      max_strobes));
        end
    endtask

    task automatic check_window(input int first_strobe);
        for (int i = 0; i < impulse_length; i++) begin
            read_addr = addr_t'(i);
            @(negedge audio_clk);
            check_sample(read_data, strobe_log[first_strobe + i],
                         $sformatf("read_data at address %0d", i));
        end
    endtask

    task automatic release_capture();
        check_flag(impulse_recorded, 1'b1, "impulse_recorded before redo");
        redo_impulse = 1'b1;
        @(negedge audio_clk);
        redo_impulse = 1'b0;
        check_flag(impulse_recorded, 1'b0, "impulse_recorded one cycle after redo");
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic test_reset_state();
        check_flag(impulse_recorded, 1'b0, "impulse_recorded after reset");
        check_sample(impulse_out, '0, "impulse_out after reset");
        repeat (3 * strobe_period) begin
            @(negedge audio_clk);
            check_flag(impulse_recorded, 1'b0, "impulse_recorded without a request");
            check_sample(impulse_out, '0, "impulse_out without a request");
        end
    endtask

    task automatic test_impulse_shape();
        int      end_strobe;
        sample_t expected;
        start_capture(16'd0, end_strobe);
        for (int t = 1; t <= 3 * strobe_period; t++) begin
            if (t >= strobe_period && t < 2 * strobe_period) begin
                expected = IMPULSE_AMP;
            end else begin
                expected = '0;
            end
            check_sample(impulse_out, expected,
                         $sformatf("impulse_out %0d cycles after request", t));
            @(negedge audio_clk);
        end
        wait_for_recorded(impulse_length + 4);
        check_window(end_strobe + 1);
        release_capture();
    endtask

    task automatic test_capture_with_delay();
        int end_strobe;
        start_capture(16'd5, end_strobe);
        wait_for_recorded(5 + impulse_length + 4);
        stored_window = end_strobe + 5 + 1;
        check_window(stored_window);
        release_capture();
    endtask

    task automatic test_zero_delay();
        int end_strobe;
        start_capture(16'd0, end_strobe);
        wait_for_recorded(impulse_length + 4);
        stored_window = end_strobe + 1;
        check_window(stored_window);
    endtask

    task automatic test_redo_recapture();
        int end_strobe;
        release_capture();
        start_capture(16'd9, end_strobe);
        wait_for_recorded(9 + impulse_length + 4);
        stored_window = end_strobe + 9 + 1;
        check_window(stored_window);
    endtask

    task automatic test_ignored_requests();
        int seen;
        int end_strobe;
        int cycles;
        wait_next_strobe(seen);  // Still in COMPLETE from the last capture.
        record_impulse_trigger = 1'b1;
        @(negedge audio_clk);
        record_impulse_trigger = 1'b0;
        repeat (3 * strobe_period) begin
            check_sample(impulse_out, '0, "impulse_out after a request in COMPLETE");
            check_flag(impulse_recorded, 1'b1, "impulse_recorded after a request in COMPLETE");
            @(negedge audio_clk);
        end
        check_window(stored_window);
        release_capture();
        start_capture(16'd4, end_strobe);
        seen = 0;
        while (seen <= end_strobe) wait_next_strobe(seen);
        record_impulse_trigger = 1'b1;  // The FSM is counting delay strobes here.
        @(negedge audio_clk);
        record_impulse_trigger = 1'b0;
        cycles = 0;
        while (impulse_recorded !== 1'b1 && cycles < (4 + impulse_length + 4) * strobe_period) begin
            check_sample(impulse_out, '0, "impulse_out after a request in DELAYING");
            @(negedge audio_clk);
            cycles++;
        end
        check_flag(impulse_recorded, 1'b1, "impulse_recorded after the capture");
        stored_window = end_strobe + 4 + 1;
        check_window(stored_window);
    endtask

    initial begin : test_sequence
        rst_in                 = 1'b1;
        record_impulse_trigger = 1'b0;
        delay_length           = '0;
        redo_impulse           = 1'b0;
        read_addr              = '0;
        repeat (reset_cycles) @(negedge audio_clk);
        rst_in = 1'b0;
        test_reset_state();
        test_impulse_shape();
        test_capture_with_delay();
        test_zero_delay();
        test_redo_recapture();
        test_ignored_requests();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+verification
common/impulse_pkg.sv
logic/impulse_generator.sv
capture/sample_counter.sv
capture/capture_fsm.sv
logic/impulse_memory.sv
logic/record_impulse.sv
verification/tb_record_impulse.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_record_impulse \
    -f all.f \
    -o sim_record_impulse

./obj_dir/sim_record_impulse
